// File: Makefile
SRCS := $(shell grep -v '^+' files.f)

obj_dir/Vtb_pp_front_end: files.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_pp_front_end -f files.f

run: obj_dir/Vtb_pp_front_end
	./obj_dir/Vtb_pp_front_end | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: files.f
verilog/pp_pkg.sv
verilog/pp_lh_fifo.sv
verilog/pp_src_arbiter.sv
verilog/pp_credit_counter.sv
verilog/pp_chunk_stage.sv
verilog/pp_front_end.sv
tb/tb_pp_front_end.sv

// File: tb/tb_pp_front_end.sv
`timescale 1ns/1ps

module tb_pp_front_end;

	localparam int WAIT_LIMIT = 200;

	logic             clk;
	logic             rst_n;
	logic             lh_valid;
	pp_pkg::pp_beat_t lh_beat;
	pp_pkg::pp_meta_t lh_meta;
	logic             ecdsa_valid;
	pp_pkg::pp_beat_t ecdsa_beat;
	pp_pkg::pp_meta_t ecdsa_meta;
	logic             pu_done;
	logic             pu_buf_rd;
	logic             ecdsa_ready;
	logic             pp_valid;
	pp_pkg::pp_out_t  pp_out;

	// reference model state
	pp_pkg::pp_out_t lh_exp [$];
	pp_pkg::pp_out_t ec_exp [$];
	int              len_q [$];
	int              model_credits;

	pp_front_end UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.lh_valid    (lh_valid),
		.lh_beat     (lh_beat),
		.lh_meta     (lh_meta),
		.ecdsa_valid (ecdsa_valid),
		.ecdsa_beat  (ecdsa_beat),
		.ecdsa_meta  (ecdsa_meta),
		.pu_done     (pu_done),
		.pu_buf_rd   (pu_buf_rd),
		.ecdsa_ready (ecdsa_ready),
		.pp_valid    (pp_valid),
		.pp_out      (pp_out)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_field(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp)
		else report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	// type in [127:124], length in [123:112] and creation time in [111:80]
	function automatic pp_pkg::pp_out_t make_beat(input int idx, input int nbeats,
		input logic [11:0] len, input logic [31:0] ctime, input pp_pkg::pp_meta_t meta);
		pp_pkg::pp_out_t b;
		b.data = {$urandom, $urandom, $urandom, $urandom};
		if (idx == 0) begin
			b.data[123:112] = len;
			b.data[111:80] = ctime;
		end
		b.sop = (idx == 0);
		b.eop = (idx == nbeats - 1);
		b.len = len;
		b.meta = meta;
		b.creation_time = ctime;
		return b;
	endfunction

	// admit if not flagged and the chunk fits the credits left
	task automatic decide_admit(input logic [11:0] len, input logic discard, output logic keep);
		keep = !discard && (int'(len) <= model_credits);
		if (keep) begin
			model_credits = model_credits - int'(len);
			len_q.push_back(int'(len));
		end
	endtask

	task automatic send_lh(input int nbeats, input logic [11:0] len, input logic discard);
		pp_pkg::pp_meta_t meta;
		pp_pkg::pp_out_t  b;
		logic [31:0]      ctime;
		logic             keep;
		meta.discard = discard;
		meta.port = 4'd1;
		meta.buf_ptr = 16'($urandom);
		ctime = $urandom;
		decide_admit(len, discard, keep);
		for (int i = 0; i < nbeats; i++) begin
			b = make_beat(i, nbeats, len, ctime, meta);
			if (keep)
				lh_exp.push_back(b);
			@(posedge clk);
			lh_valid <= 1'b1;
			lh_beat <= '{sop: b.sop, eop: b.eop, data: b.data};
			lh_meta <= meta;
		end
		@(posedge clk);
		lh_valid <= 1'b0;
	endtask

	task automatic wait_ecdsa_accept();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!ecdsa_ready) begin
			cycles++;
			assert (cycles < WAIT_LIMIT)
			else report_failure("timeout: ecdsa_ready never rose for a held beat");
			@(negedge clk);
		end
	endtask

	task automatic send_ecdsa(input int nbeats, input logic [11:0] len, input logic discard);
		pp_pkg::pp_meta_t meta;
		pp_pkg::pp_out_t  b;
		logic [31:0]      ctime;
		logic             keep;
		meta.discard = discard;
		meta.port = 4'd2;
		meta.buf_ptr = 16'($urandom);
		ctime = $urandom;
		decide_admit(len, discard, keep);
		for (int i = 0; i < nbeats; i++) begin
			b = make_beat(i, nbeats, len, ctime, meta);
			if (keep)
				ec_exp.push_back(b);
			@(posedge clk);
			ecdsa_valid <= 1'b1;
			ecdsa_beat <= '{sop: b.sop, eop: b.eop, data: b.data};
			ecdsa_meta <= meta;
			wait_ecdsa_accept();
		end
		@(posedge clk);
		ecdsa_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (lh_exp.size() > 0 || ec_exp.size() > 0 || UUT.lh_head_valid || pp_valid) begin
			cycles++;
			assert (cycles < WAIT_LIMIT)
			else report_failure("timeout: expected output packets did not come out");
			@(negedge clk);
		end
	endtask

	task automatic pulse_done();
		@(posedge clk);
		pu_done <= 1'b1;
		@(posedge clk);
		pu_done <= 1'b0;
		model_credits = model_credits + len_q.pop_front();
	endtask

	task automatic pulse_buf_rd(input int n);
		@(posedge clk);
		pu_buf_rd <= 1'b1;
		repeat (n) @(posedge clk);
		pu_buf_rd <= 1'b0;
		model_credits = model_credits + n;
	endtask

	task automatic check_credits();
		@(negedge clk);
		check_field("credits", 128'(UUT.credits), 128'(model_credits));
	endtask

	// ####################################################################
	// output monitor and scoreboard
	// ####################################################################

	initial begin : monitor
		pp_pkg::pp_out_t exp;
		logic            in_pkt;
		logic [3:0]      cur_port;
		in_pkt = 1'b0;
		cur_port = '0;
		forever begin
			@(negedge clk);
			if (rst_n && pp_valid) begin
				if (pp_out.sop) begin
					assert (!in_pkt)
					else report_failure("output sop arrived before previous eop");
					cur_port = pp_out.meta.port;
					in_pkt = 1'b1;
				end else begin
					assert (in_pkt) else report_failure("output beat outside any packet");
					check_field("pp_out.meta.port", 128'(pp_out.meta.port), 128'(cur_port));
				end
				if (pp_out.meta.port == 4'd1) begin
					assert (lh_exp.size() > 0)
					else report_failure("unexpected output beat from LH");
					exp = lh_exp.pop_front();
				end else begin
					assert (pp_out.meta.port == 4'd2 && ec_exp.size() > 0)
					else report_failure("unexpected output beat from ECDSA or unknown port");
					exp = ec_exp.pop_front();
				end
				check_field("pp_out.sop", 128'(pp_out.sop), 128'(exp.sop));
				check_field("pp_out.eop", 128'(pp_out.eop), 128'(exp.eop));
				check_field("pp_out.data", pp_out.data, exp.data);
				check_field("pp_out.len", 128'(pp_out.len), 128'(exp.len));
				check_field("pp_out.meta", 128'(pp_out.meta), 128'(exp.meta));
				check_field("pp_out.creation_time", 128'(pp_out.creation_time),
					128'(exp.creation_time));
				if (pp_out.eop)
					in_pkt = 1'b0;
			end
		end
	end

	// ####################################################################
	// test sequence
	// ####################################################################

	initial begin
		void'($urandom(32'h5653));
		rst_n = 1'b0;
		lh_valid = 1'b0;
		lh_beat = '0;
		lh_meta = '0;
		ecdsa_valid = 1'b0;
		ecdsa_beat = '0;
		ecdsa_meta = '0;
		pu_done = 1'b0;
		pu_buf_rd = 1'b0;
		model_credits = 1024;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		@(negedge clk);
		check_field("ecdsa_ready", 128'(ecdsa_ready), 128'(1'b0));
		check_field("pp_valid", 128'(pp_valid), 128'(1'b0));
		check_credits();

		// single packets from each source
		send_lh(3, 12'($urandom_range(64, 1)), 1'b0);
		wait_drain();
		send_ecdsa(3, 12'($urandom_range(64, 1)), 1'b0);
		wait_drain();
		check_credits();
		while (len_q.size() > 0)
			pulse_done();

		// both sources busy at once
		fork
			begin
				send_lh(3, 12'($urandom_range(64, 1)), 1'b0);
				send_lh(2, 12'($urandom_range(64, 1)), 1'b0);
			end
			begin
				send_ecdsa(3, 12'($urandom_range(64, 1)), 1'b0);
				send_ecdsa(2, 12'($urandom_range(64, 1)), 1'b0);
			end
		join
		wait_drain();
		check_credits();

		// flagged packets vanish and keep their credits
		send_lh(2, 12'd40, 1'b1);
		send_ecdsa(2, 12'd40, 1'b1);
		wait_drain();
		check_credits();
		while (len_q.size() > 0)
			pulse_done();
		check_credits();

		// fill the buffer, then free it by done and by read strobes
		send_lh(2, 12'd300, 1'b0);
		send_lh(2, 12'd300, 1'b0);
		send_lh(2, 12'd300, 1'b0);
		send_lh(2, 12'd200, 1'b0);
		wait_drain();
		check_credits();
		pulse_done();
		check_credits();
		send_lh(2, 12'd200, 1'b0);
		send_lh(2, 12'd250, 1'b0);
		wait_drain();
		check_credits();
		pulse_buf_rd(30);
		check_credits();
		send_lh(2, 12'd250, 1'b0);
		wait_drain();
		check_credits();
		while (len_q.size() > 0)
			pulse_done();
		check_credits();

		$display(">>> PASS");
		$finish;
	end

endmodule

// File: verilog/pp_chunk_stage.sv
`timescale 1ns/1ps

module pp_chunk_stage (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              in_valid,
	input  pp_pkg::pp_beat_t                  in_beat,
	input  pp_pkg::pp_meta_t                  in_meta,
	input  logic [pp_pkg::PP_CREDIT_W-1:0]    credits,
	output logic                              admit,
	output logic [pp_pkg::PP_CHUNK_LEN_W-1:0] admit_len,
	output logic                              pp_valid,
	output pp_pkg::pp_out_t                   pp_out
);

	pp_pkg::pp_word_u word;

	logic [pp_pkg::PP_CHUNK_LEN_W-1:0] credits_ext;
	logic                              sop_beat;
	logic                              sop_ok;
	logic                              keep;

	// decision of the packet in flight
	logic keep_q;

	assign word = in_beat.data;

	assign credits_ext = {{(pp_pkg::PP_CHUNK_LEN_W - pp_pkg::PP_CREDIT_W){1'b0}}, credits};

	// ####################################################################
	// admit or discard on the first beat
	// ####################################################################

	assign sop_beat = in_valid && in_beat.sop;

	// chunk must fit in what the buffer has left right now
	assign sop_ok = !in_meta.discard && (word.hdr.chunk_len <= credits_ext);

	assign admit = sop_beat && sop_ok;
	assign admit_len = word.hdr.chunk_len;

	// sop decides, later beats follow it
	assign keep = in_beat.sop ? sop_ok : keep_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			keep_q <= 1'b0;
			pp_valid <= 1'b0;
		end else begin
			pp_valid <= in_valid && keep;
			if (sop_beat)
				keep_q <= sop_ok;
		end
	end

	// ####################################################################
	// output beat
	// ####################################################################

	always_ff @(posedge clk) begin
		if (in_valid) begin
			pp_out.sop <= in_beat.sop;
			pp_out.eop <= in_beat.eop;
			pp_out.data <= word.raw;
		end
		// header fields stay for the rest of the packet
		if (sop_beat) begin
			pp_out.len <= word.hdr.chunk_len;
			pp_out.creation_time <= word.hdr.creation_time;
			pp_out.meta <= in_meta;
		end
	end

endmodule

// File: verilog/pp_credit_counter.sv
`timescale 1ns/1ps

module pp_credit_counter (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              admit,
	input  logic [pp_pkg::PP_CHUNK_LEN_W-1:0] admit_len,
	input  logic                              pu_done,
	input  logic                              pu_buf_rd,
	output logic [pp_pkg::PP_CREDIT_W-1:0]    credits
);

	// lengths of admitted chunks, oldest first
	logic [pp_pkg::PP_CHUNK_LEN_W-1:0] len_mem [0:(1 << pp_pkg::PP_LEN_FIFO_DEPTH_W)-1];

	logic [pp_pkg::PP_LEN_FIFO_DEPTH_W:0] len_wr_ptr;
	logic [pp_pkg::PP_LEN_FIFO_DEPTH_W:0] len_rd_ptr;
	logic                                 len_empty;
	logic                                 len_pop;
	logic [pp_pkg::PP_CHUNK_LEN_W-1:0]    ret_len;

	// one bit of headroom over the chunk length
	logic [pp_pkg::PP_CHUNK_LEN_W:0] credits_ext;
	logic [pp_pkg::PP_CHUNK_LEN_W:0] next_credits;

	assign len_empty = (len_wr_ptr == len_rd_ptr);
	assign len_pop = pu_done && !len_empty;
	assign ret_len = len_pop ? len_mem[len_rd_ptr[pp_pkg::PP_LEN_FIFO_DEPTH_W-1:0]] : '0;

	assign credits_ext = {{(pp_pkg::PP_CHUNK_LEN_W + 1 - pp_pkg::PP_CREDIT_W){1'b0}}, credits};

	// take, return and read strobe all land in one update
	always_comb begin
		next_credits = credits_ext + {1'b0, ret_len} +
			{{pp_pkg::PP_CHUNK_LEN_W{1'b0}}, pu_buf_rd};
		if (admit)
			next_credits = next_credits - {1'b0, admit_len};
	end

	always_ff @(posedge clk) begin
		if (admit)
			len_mem[len_wr_ptr[pp_pkg::PP_LEN_FIFO_DEPTH_W-1:0]] <= admit_len;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credits <= pp_pkg::PP_BUF_CREDITS;
			len_wr_ptr <= '0;
			len_rd_ptr <= '0;
		end else begin
			credits <= next_credits[pp_pkg::PP_CREDIT_W-1:0];
			if (admit)
				len_wr_ptr <= len_wr_ptr + 1'b1;
			if (len_pop)
				len_rd_ptr <= len_rd_ptr + 1'b1;
		end
	end

endmodule

// File: verilog/pp_front_end.sv
`timescale 1ns/1ps

module pp_front_end (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              lh_valid,
	input  pp_pkg::pp_beat_t  lh_beat,
	input  pp_pkg::pp_meta_t  lh_meta,
	input  logic              ecdsa_valid,
	input  pp_pkg::pp_beat_t  ecdsa_beat,
	input  pp_pkg::pp_meta_t  ecdsa_meta,
	input  logic              pu_done,
	input  logic              pu_buf_rd,
	output logic              ecdsa_ready,
	output logic              pp_valid,
	output pp_pkg::pp_out_t   pp_out
);

	// LH FIFO head
	logic             lh_head_valid;
	pp_pkg::pp_beat_t lh_head;
	logic             lh_pkt_avail;
	pp_pkg::pp_meta_t lh_head_meta;
	logic             lh_rd;

	// selected beat
	logic             in_valid;
	pp_pkg::pp_beat_t in_beat;
	pp_pkg::pp_meta_t in_meta;

	// credit loop
	logic                              admit;
	logic [pp_pkg::PP_CHUNK_LEN_W-1:0] admit_len;
	logic [pp_pkg::PP_CREDIT_W-1:0]    credits;

	pp_lh_fifo u_lh_fifo (
		.clk           (clk),
		.rst_n         (rst_n),
		.lh_valid      (lh_valid),
		.lh_beat       (lh_beat),
		.lh_meta       (lh_meta),
		.lh_rd         (lh_rd),
		.lh_head_valid (lh_head_valid),
		.lh_head       (lh_head),
		.lh_pkt_avail  (lh_pkt_avail),
		.lh_head_meta  (lh_head_meta)
	);

	pp_src_arbiter u_src_arbiter (
		.clk           (clk),
		.rst_n         (rst_n),
		.lh_head_valid (lh_head_valid),
		.lh_head       (lh_head),
		.lh_pkt_avail  (lh_pkt_avail),
		.lh_head_meta  (lh_head_meta),
		.ecdsa_valid   (ecdsa_valid),
		.ecdsa_beat    (ecdsa_beat),
		.ecdsa_meta    (ecdsa_meta),
		.ecdsa_ready   (ecdsa_ready),
		.lh_rd         (lh_rd),
		.in_valid      (in_valid),
		.in_beat       (in_beat),
		.in_meta       (in_meta)
	);

	pp_chunk_stage u_chunk_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_beat   (in_beat),
		.in_meta   (in_meta),
		.credits   (credits),
		.admit     (admit),
		.admit_len (admit_len),
		.pp_valid  (pp_valid),
		.pp_out    (pp_out)
	);

	pp_credit_counter u_credit_counter (
		.clk       (clk),
		.rst_n     (rst_n),
		.admit     (admit),
		.admit_len (admit_len),
		.pu_done   (pu_done),
		.pu_buf_rd (pu_buf_rd),
		.credits   (credits)
	);

endmodule

// File: verilog/pp_lh_fifo.sv
`timescale 1ns/1ps

module pp_lh_fifo (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              lh_valid,
	input  pp_pkg::pp_beat_t  lh_beat,
	input  pp_pkg::pp_meta_t  lh_meta,
	input  logic              lh_rd,
	output logic              lh_head_valid,
	output pp_pkg::pp_beat_t  lh_head,
	output logic              lh_pkt_avail,
	output pp_pkg::pp_meta_t  lh_head_meta
);

	pp_pkg::pp_beat_t beat_mem [0:(1 << pp_pkg::PP_LH_FIFO_DEPTH_W)-1];
	pp_pkg::pp_meta_t meta_mem [0:(1 << pp_pkg::PP_LH_META_DEPTH_W)-1];

	logic [pp_pkg::PP_LH_FIFO_DEPTH_W:0] beat_wr_ptr;
	logic [pp_pkg::PP_LH_FIFO_DEPTH_W:0] beat_rd_ptr;
	logic [pp_pkg::PP_LH_META_DEPTH_W:0] meta_wr_ptr;
	logic [pp_pkg::PP_LH_META_DEPTH_W:0] meta_rd_ptr;

	logic beat_full;
	logic meta_full;
	logic beat_wr;
	logic beat_rd;
	logic meta_wr;
	logic meta_rd;

	assign beat_full = (beat_wr_ptr[pp_pkg::PP_LH_FIFO_DEPTH_W] !=
		beat_rd_ptr[pp_pkg::PP_LH_FIFO_DEPTH_W]) &&
		(beat_wr_ptr[pp_pkg::PP_LH_FIFO_DEPTH_W-1:0] ==
		beat_rd_ptr[pp_pkg::PP_LH_FIFO_DEPTH_W-1:0]);
	assign meta_full = (meta_wr_ptr[pp_pkg::PP_LH_META_DEPTH_W] !=
		meta_rd_ptr[pp_pkg::PP_LH_META_DEPTH_W]) &&
		(meta_wr_ptr[pp_pkg::PP_LH_META_DEPTH_W-1:0] ==
		meta_rd_ptr[pp_pkg::PP_LH_META_DEPTH_W-1:0]);

	assign lh_head_valid = (beat_wr_ptr != beat_rd_ptr);
	assign lh_pkt_avail = (meta_wr_ptr != meta_rd_ptr);
	assign lh_head = beat_mem[beat_rd_ptr[pp_pkg::PP_LH_FIFO_DEPTH_W-1:0]];
	assign lh_head_meta = meta_mem[meta_rd_ptr[pp_pkg::PP_LH_META_DEPTH_W-1:0]];

	// beats past the 16th outstanding one are dropped
	assign beat_wr = lh_valid && !beat_full;
	assign beat_rd = lh_rd && lh_head_valid;
	// one meta entry per packet, released when its eop leaves
	assign meta_wr = beat_wr && lh_beat.sop && !meta_full;
	assign meta_rd = beat_rd && lh_head.eop && lh_pkt_avail;

	always_ff @(posedge clk) begin
		if (beat_wr)
			beat_mem[beat_wr_ptr[pp_pkg::PP_LH_FIFO_DEPTH_W-1:0]] <= lh_beat;
		if (meta_wr)
			meta_mem[meta_wr_ptr[pp_pkg::PP_LH_META_DEPTH_W-1:0]] <= lh_meta;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			beat_wr_ptr <= '0;
			beat_rd_ptr <= '0;
			meta_wr_ptr <= '0;
			meta_rd_ptr <= '0;
		end else begin
			if (beat_wr)
				beat_wr_ptr <= beat_wr_ptr + 1'b1;
			if (beat_rd)
				beat_rd_ptr <= beat_rd_ptr + 1'b1;
			if (meta_wr)
				meta_wr_ptr <= meta_wr_ptr + 1'b1;
			if (meta_rd)
				meta_rd_ptr <= meta_rd_ptr + 1'b1;
		end
	end

endmodule

// File: verilog/pp_pkg.sv
package pp_pkg;

	// ####################################################################
	// widths and depths
	// ####################################################################

	localparam int PP_DATA_W = 128;
	localparam int PP_CHUNK_TYPE_W = 4;
	localparam int PP_CHUNK_LEN_W = 12;
	localparam int PP_TIME_W = 32;
	localparam int PP_HDR_REST_W = PP_DATA_W - PP_CHUNK_TYPE_W - PP_CHUNK_LEN_W - PP_TIME_W;

	localparam int PP_CREDIT_W = 11;
	localparam logic [PP_CREDIT_W-1:0] PP_BUF_CREDITS = PP_CREDIT_W'(1024);

	// 16 beats
	localparam int PP_LH_FIFO_DEPTH_W = 4;
	// 4 packets
	localparam int PP_LH_META_DEPTH_W = 2;
	// 4 admitted chunks
	localparam int PP_LEN_FIFO_DEPTH_W = 2;

	// ####################################################################
	// beat and meta types
	// ####################################################################

	// one per packet, taken on sop
	typedef struct packed {
		logic        discard;
		logic [3:0]  port;
		logic [15:0] buf_ptr;
	} pp_meta_t;

	typedef struct packed {
		logic                 sop;
		logic                 eop;
		logic [PP_DATA_W-1:0] data;
	} pp_beat_t;

	// first beat of a packet
	typedef struct packed {
		logic [PP_CHUNK_TYPE_W-1:0] chunk_type;
		logic [PP_CHUNK_LEN_W-1:0]  chunk_len;
		logic [PP_TIME_W-1:0]       creation_time;
		logic [PP_HDR_REST_W-1:0]   rest;
	} pp_hdr_t;

	// header on sop, raw data on every later beat
	typedef union packed {
		logic [PP_DATA_W-1:0] raw;
		pp_hdr_t              hdr;
	} pp_word_u;

	typedef struct packed {
		logic                      sop;
		logic                      eop;
		logic [PP_DATA_W-1:0]      data;
		logic [PP_CHUNK_LEN_W-1:0] len;
		pp_meta_t                  meta;
		logic [PP_TIME_W-1:0]      creation_time;
	} pp_out_t;

endpackage

// File: verilog/pp_src_arbiter.sv
`timescale 1ns/1ps

module pp_src_arbiter (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              lh_head_valid,
	input  pp_pkg::pp_beat_t  lh_head,
	input  logic              lh_pkt_avail,
	input  pp_pkg::pp_meta_t  lh_head_meta,
	input  logic              ecdsa_valid,
	input  pp_pkg::pp_beat_t  ecdsa_beat,
	input  pp_pkg::pp_meta_t  ecdsa_meta,
	output logic              ecdsa_ready,
	output logic              lh_rd,
	output logic              in_valid,
	output pp_pkg::pp_beat_t  in_beat,
	output pp_pkg::pp_meta_t  in_meta
);

	// FSM state, 1 is LH and 0 is ECDSA
	logic sel_lh;

	logic lh_eop_rd;
	logic ecdsa_acc;
	logic ecdsa_eop_acc;
	logic to_ecdsa;
	logic to_lh;

	assign ecdsa_ready = !sel_lh;
	assign lh_rd = sel_lh && lh_head_valid;

	assign lh_eop_rd = lh_rd && lh_head.eop;
	assign ecdsa_acc = ecdsa_valid && ecdsa_ready;
	assign ecdsa_eop_acc = ecdsa_acc && ecdsa_beat.eop;

	// ####################################################################
	// switch only between packets
	// ####################################################################

	// LH packet stays pending until its eop is read
	assign to_ecdsa = ecdsa_valid && (!lh_pkt_avail || lh_eop_rd);
	// ECDSA packets arrive without gaps so valid low means idle
	assign to_lh = lh_pkt_avail && (!ecdsa_valid || ecdsa_eop_acc);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sel_lh <= 1'b1;
		end else if (sel_lh && to_ecdsa) begin
			sel_lh <= 1'b0;
		end else if (!sel_lh && to_lh) begin
			sel_lh <= 1'b1;
		end
	end

	// selected beat goes straight through
	always_comb begin
		if (sel_lh) begin
			in_valid = lh_head_valid;
			in_beat = lh_head;
			in_meta = lh_head_meta;
		end else begin
			in_valid = ecdsa_acc;
			in_beat = ecdsa_beat;
			in_meta = ecdsa_meta;
		end
	end

endmodule
